//--- files.f
hdl/dbg_proto_pkg.sv
hdl/target_bus_pkg.sv
hdl/pin_sync.sv
hdl/spi_target.sv
hdl/cmd_parser.sv
hdl/debug_regs.sv
hdl/bp_matcher.sv
hdl/shadow_mem.sv
hdl/dbg_top.sv
tests/tb_clock.sv
tests/tb_top.sv

//--- hdl/bp_matcher.sv
`timescale 1ns/1ns

module bp_matcher #(
  parameter int NUM_BP = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  target_bus_pkg::bus_pins_t              bus,
  input  target_bus_pkg::bus_pins_t              bus_prev,
  input  target_bus_pkg::bp_entry_t [NUM_BP-1:0] bp_table,
  input  logic                                   bp_enable,
  input  dbg_proto_pkg::cmd_t                    cmd,
  input  logic                                   action,
  output logic                                   halt,
  output logic [2:0]                             hit_index
);

  typedef enum logic [1:0] {
    st_run,
    st_stop,
    st_resume
  } state_t;

  state_t      state;
  logic [15:0] stop_addr;
  logic        rd_fall;
  logic        match;
  logic [2:0]  match_idx;

  assign rd_fall = bus_prev.rd_n & ~bus.rd_n;
  assign halt    = state != st_run;

  // Scan from the top so the lowest matching slot wins
  always_comb begin
    match     = 1'b0;
    match_idx = 3'd0;
    for (int i = NUM_BP - 1; i >= 0; i--) begin
      if (bp_table[i].active && bp_table[i].addr == bus.addr) begin
        match     = 1'b1;
        match_idx = 3'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_run;
      hit_index <= 3'd0;
    end else begin
      case (state)
        st_run: begin
          if (rd_fall && bp_enable && match) begin
            state     <= st_stop;
            hit_index <= match_idx;
            stop_addr <= bus.addr;
          end
        end
        st_stop: begin
          if (action && cmd.op == dbg_proto_pkg::resume) begin
            state <= st_resume;
          end
        end
        // Let the stopped read go through once without matching
        st_resume: begin
          if (rd_fall && bus.addr == stop_addr) begin
            state <= st_run;
          end
        end
        default: state <= st_run;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) $rose(halt) |-> $past(bp_enable))
    else $error("bp_matcher: halt raised with breakpoints disabled");

endmodule

//--- hdl/cmd_parser.sv
`timescale 1ns/1ns

module cmd_parser (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          rx_byte,
  input  logic                rx_valid,
  input  logic                frame_start,
  output dbg_proto_pkg::cmd_t cmd,
  output logic                action,
  output logic                reply_pending
);

  typedef enum logic {
    st_idle,
    st_read_params
  } state_t;

  state_t                 state;
  logic [1:0]             remaining;
  logic [1:0]             idx;
  dbg_proto_pkg::opcode_t op_in;

  assign op_in = dbg_proto_pkg::opcode_t'(rx_byte);

  // Commands followed by a dummy byte carrying the answer
  function automatic logic answers(dbg_proto_pkg::opcode_t op);
    return (op == dbg_proto_pkg::get_cookie) || (op == dbg_proto_pkg::get_version) ||
           (op == dbg_proto_pkg::mem_peek);
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= st_idle;
      remaining     <= 2'd0;
      idx           <= 2'd0;
      action        <= 1'b0;
      reply_pending <= 1'b0;
    end else begin
      action        <= 1'b0;
      reply_pending <= 1'b0;
      if (frame_start) begin
        state <= st_idle;
      end else if (rx_valid) begin
        case (state)
          st_idle: begin
            cmd.op <= op_in;
            idx    <= 2'd0;
            case (op_in)
              dbg_proto_pkg::get_cookie, dbg_proto_pkg::get_version,
              dbg_proto_pkg::enable_breakpoints, dbg_proto_pkg::disable_breakpoints,
              dbg_proto_pkg::resume: begin
                action        <= 1'b1;
                reply_pending <= answers(op_in);
              end
              dbg_proto_pkg::mem_poke, dbg_proto_pkg::mem_peek,
              dbg_proto_pkg::set_breakpoint, dbg_proto_pkg::clear_breakpoint: begin
                remaining <= dbg_proto_pkg::param_count(op_in);
                state     <= st_read_params;
              end
              // Unknown opcodes are dropped
              default: ;
            endcase
          end
          st_read_params: begin
            case (idx)
              2'd0:    cmd.p0 <= rx_byte;
              2'd1:    cmd.p1 <= rx_byte;
              default: cmd.p2 <= rx_byte;
            endcase
            idx <= idx + 2'd1;
            if (remaining == 2'd1) begin
              action        <= 1'b1;
              reply_pending <= answers(cmd.op);
              state         <= st_idle;
            end else begin
              remaining <= remaining - 2'd1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // Downstream blocks act once per command
  assert property (@(posedge clk) disable iff (!rst_n) action |=> !action)
    else $error("cmd_parser: action held longer than one cycle");

endmodule

//--- hdl/dbg_proto_pkg.sv
package dbg_proto_pkg;

  // Command codes sent by the host as the first byte of a frame
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    mem_poke            = 8'd1,
    mem_peek            = 8'd2,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    resume              = 8'd13,
    get_version         = 8'd15
  } opcode_t;

  // One complete command made of an opcode and up to three parameter bytes
  typedef struct packed {
    opcode_t    op;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } cmd_t;

  localparam logic [7:0] COOKIE = 8'haf;
  // Major 0 and minor 2
  localparam logic [7:0] VERSION = {3'd0, 5'd2};

  // Parameter bytes that follow each opcode
  function automatic logic [1:0] param_count(opcode_t op);
    case (op)
      mem_poke:         return 2'd3;
      mem_peek:         return 2'd2;
      set_breakpoint:   return 2'd3;
      clear_breakpoint: return 2'd1;
      default:          return 2'd0;
    endcase
  endfunction

endpackage

//--- hdl/dbg_top.sv
`timescale 1ns/1ns

module dbg_top #(
  parameter int NUM_BP     = 8,
  parameter int MEM_ADDR_W = 10
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  target_bus_pkg::spi_pins_t spi_in,
  input  target_bus_pkg::bus_pins_t bus_in,
  output logic                      miso,
  output logic                      halt,
  output logic [2:0]                hit_index
);

  target_bus_pkg::spi_pins_t              spi;
  target_bus_pkg::spi_pins_t              spi_prev;
  target_bus_pkg::bus_pins_t              bus;
  target_bus_pkg::bus_pins_t              bus_prev;
  target_bus_pkg::bp_entry_t [NUM_BP-1:0] bp_table;
  dbg_proto_pkg::cmd_t                    cmd;
  logic [7:0]                             rx_byte;
  logic                                   rx_valid;
  logic                                   frame_start;
  logic                                   action;
  logic                                   reply_pending;
  logic                                   bp_enable;
  logic [7:0]                             regs_reply;
  logic                                   regs_reply_valid;
  logic [7:0]                             mem_reply;
  logic                                   mem_reply_valid;

  pin_sync #(.T(target_bus_pkg::spi_pins_t)) u_spi_sync (
    .clk(clk), .rst_n(rst_n), .d(spi_in), .q(spi), .q_prev(spi_prev)
  );

  pin_sync #(.T(target_bus_pkg::bus_pins_t)) u_bus_sync (
    .clk(clk), .rst_n(rst_n), .d(bus_in), .q(bus), .q_prev(bus_prev)
  );

  spi_target u_spi_target (
    .clk(clk), .rst_n(rst_n), .spi(spi), .spi_prev(spi_prev),
    .reply_pending(reply_pending),
    .regs_reply(regs_reply), .regs_reply_valid(regs_reply_valid),
    .mem_reply(mem_reply), .mem_reply_valid(mem_reply_valid),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .frame_start(frame_start), .miso(miso)
  );

  cmd_parser u_cmd_parser (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .frame_start(frame_start), .cmd(cmd), .action(action), .reply_pending(reply_pending)
  );

  debug_regs #(.NUM_BP(NUM_BP)) u_debug_regs (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .action(action),
    .bp_table(bp_table), .bp_enable(bp_enable),
    .reply(regs_reply), .reply_valid(regs_reply_valid)
  );

  bp_matcher #(.NUM_BP(NUM_BP)) u_bp_matcher (
    .clk(clk), .rst_n(rst_n), .bus(bus), .bus_prev(bus_prev),
    .bp_table(bp_table), .bp_enable(bp_enable), .cmd(cmd), .action(action),
    .halt(halt), .hit_index(hit_index)
  );

  shadow_mem #(.MEM_ADDR_W(MEM_ADDR_W)) u_shadow_mem (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .action(action),
    .reply(mem_reply), .reply_valid(mem_reply_valid)
  );

endmodule

//--- hdl/debug_regs.sv
`timescale 1ns/1ns

module debug_regs #(
  parameter int NUM_BP = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  dbg_proto_pkg::cmd_t                    cmd,
  input  logic                                   action,
  output target_bus_pkg::bp_entry_t [NUM_BP-1:0] bp_table,
  output logic                                   bp_enable,
  output logic [7:0]                             reply,
  output logic                                   reply_valid
);

  localparam int IDX_W = (NUM_BP > 1) ? $clog2(NUM_BP) : 1;

  logic             idx_ok;
  logic [IDX_W-1:0] idx;

  // Out of range slots are ignored
  assign idx_ok = cmd.p0 < NUM_BP;
  assign idx    = cmd.p0[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bp_enable   <= 1'b0;
      reply_valid <= 1'b0;
      for (int i = 0; i < NUM_BP; i++) begin
        bp_table[i].active <= 1'b0;
      end
    end else begin
      reply_valid <= 1'b0;
      if (action) begin
        case (cmd.op)
          dbg_proto_pkg::set_breakpoint: begin
            if (idx_ok) begin
              bp_table[idx].addr   <= {cmd.p2, cmd.p1};
              bp_table[idx].active <= 1'b1;
            end
          end
          dbg_proto_pkg::clear_breakpoint: begin
            if (idx_ok) begin
              bp_table[idx].active <= 1'b0;
            end
          end
          dbg_proto_pkg::enable_breakpoints:  bp_enable <= 1'b1;
          dbg_proto_pkg::disable_breakpoints: bp_enable <= 1'b0;
          dbg_proto_pkg::get_cookie: begin
            reply       <= dbg_proto_pkg::COOKIE;
            reply_valid <= 1'b1;
          end
          dbg_proto_pkg::get_version: begin
            reply       <= dbg_proto_pkg::VERSION;
            reply_valid <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hdl/pin_sync.sv
`timescale 1ns/1ns

module pin_sync #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  T     d,
  output T     q,
  output T     q_prev
);

  T meta;

  // Two stages into clk and one more for edge detection
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta   <= '0;
      q      <= '0;
      q_prev <= '0;
    end else begin
      meta   <= d;
      q      <= meta;
      q_prev <= q;
    end
  end

endmodule

//--- hdl/shadow_mem.sv
`timescale 1ns/1ns

module shadow_mem #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic                clk,
  input  logic                rst_n,
  input  dbg_proto_pkg::cmd_t cmd,
  input  logic                action,
  output logic [7:0]          reply,
  output logic                reply_valid
);

  logic [7:0]            mem [2**MEM_ADDR_W];
  logic [15:0]           full_addr;
  logic [MEM_ADDR_W-1:0] addr;
  logic [7:0]            rd_data;
  logic                  peek_s1;

  assign full_addr = {cmd.p1, cmd.p0};
  assign addr      = full_addr[MEM_ADDR_W-1:0];

  // Registered read followed by an output register
  always_ff @(posedge clk) begin
    if (action && cmd.op == dbg_proto_pkg::mem_poke) begin
      mem[addr] <= cmd.p2;
    end
    rd_data <= mem[addr];
    reply   <= rd_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      peek_s1     <= 1'b0;
      reply_valid <= 1'b0;
    end else begin
      peek_s1     <= action && cmd.op == dbg_proto_pkg::mem_peek;
      reply_valid <= peek_s1;
    end
  end

endmodule

//--- hdl/spi_target.sv
`timescale 1ns/1ns

module spi_target (
  input  logic                     clk,
  input  logic                     rst_n,
  input  target_bus_pkg::spi_pins_t spi,
  input  target_bus_pkg::spi_pins_t spi_prev,
  input  logic                     reply_pending,
  input  logic [7:0]               regs_reply,
  input  logic                     regs_reply_valid,
  input  logic [7:0]               mem_reply,
  input  logic                     mem_reply_valid,
  output logic [7:0]               rx_byte,
  output logic                     rx_valid,
  output logic                     frame_start,
  output logic                     miso
);

  logic       in_frame;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic [7:0] shift_in;
  logic [7:0] tx_reg;
  logic       reply_armed;

  assign in_frame    = ~spi.cs_n;
  assign sck_rise    = spi.sck & ~spi_prev.sck;
  assign sck_fall    = ~spi.sck & spi_prev.sck;
  assign frame_start = spi_prev.cs_n & ~spi.cs_n;
  assign rx_byte     = shift_in;
  assign miso        = tx_reg[7];

  // MOSI sampled MSB first on the SCK rising edge
  always_ff @(posedge clk) begin
    if (in_frame && sck_rise) begin
      shift_in <= {shift_in[6:0], spi.mosi};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt     <= 3'd0;
      rx_valid    <= 1'b0;
      reply_armed <= 1'b0;
      tx_reg      <= 8'd0;
    end else begin
      rx_valid <= 1'b0;
      if (!in_frame) begin
        bit_cnt     <= 3'd0;
        reply_armed <= 1'b0;
        tx_reg      <= 8'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            // Dummy byte under a reply is not passed on
            rx_valid    <= ~reply_armed;
            reply_armed <= 1'b0;
          end
        end
        if (reply_pending) begin
          reply_armed <= 1'b1;
        end
        // MSB shows on MISO as soon as loaded and the rest follow on falling edges
        if (regs_reply_valid) begin
          tx_reg <= regs_reply;
        end else if (mem_reply_valid) begin
          tx_reg <= mem_reply;
        end else if (sck_fall && reply_armed && bit_cnt != 3'd0) begin
          tx_reg <= {tx_reg[6:0], 1'b0};
        end
      end
    end
  end

  // Only one action block answers per command
  assert property (@(posedge clk) disable iff (!rst_n)
    !(regs_reply_valid && mem_reply_valid))
    else $error("spi_target: register and memory replies collide");

endmodule

//--- hdl/target_bus_pkg.sv
package target_bus_pkg;

  // Host SPI link as seen at the target pins
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // Retro computer address bus and read strobe
  typedef struct packed {
    logic [15:0] addr;
    logic        rd_n;
  } bus_pins_t;

  // One breakpoint slot
  typedef struct packed {
    logic [15:0] addr;
    logic        active;
  } bp_entry_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the debug core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  // Free running clock that starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int MEM_ADDR_W = 10;
  localparam int MEM_MASK   = (1 << MEM_ADDR_W) - 1;

  logic                      clk;
  logic                      rst_n;
  target_bus_pkg::spi_pins_t spi_in;
  target_bus_pkg::bus_pins_t bus_in;
  logic                      miso;
  logic                      halt;
  logic [2:0]                hit_index;

  int          seed;
  int          k;
  logic        expect_run;
  logic        expect_halted;
  logic [2:0]  exp_hit;
  logic [7:0]  reply;
  logic [7:0]  data;
  logic [15:0] addr;
  logic [15:0] bp_addr;
  logic [15:0] other_addr;
  logic [15:0] dup_addr;
  logic [7:0]  mem_model [int];

  tb_clock #(.PERIOD(100)) clock_gen (.clk(clk));

  dbg_top #(.NUM_BP(8), .MEM_ADDR_W(MEM_ADDR_W)) UUT (
    .clk(clk), .rst_n(rst_n), .spi_in(spi_in), .bus_in(bus_in),
    .miso(miso), .halt(halt), .hit_index(hit_index)
  );

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  run_check: assert property (@(posedge clk) disable iff (!rst_n) expect_run |-> !halt)
    else begin
      $display("CHECK FAILED at %0t: halt high while the target should run", $time);
      abort_run();
    end

  stop_check: assert property (@(posedge clk) disable iff (!rst_n) expect_halted |-> halt)
    else begin
      $display("CHECK FAILED at %0t: halt low while the target should stay stopped", $time);
      abort_run();
    end

  // Index of the slot that stopped the target
  hit_check: assert property (@(posedge clk) disable iff (!rst_n) halt |-> hit_index == exp_hit)
    else begin
      $display("CHECK FAILED at %0t: hit_index %0d, expected %0d", $time, hit_index, exp_hit);
      abort_run();
    end

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s gave %02h, expected %02h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_halt(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (halt !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (halt !== level) begin
      $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, limit);
      abort_run();
    end
  endtask

  // Mode 0 transfer with MSB first and a half period of 4 clk
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      spi_in.mosi <= tx[i];
      repeat (4) @(posedge clk);
      rx[i] = miso;
      spi_in.sck <= 1'b1;
      repeat (4) @(posedge clk);
      spi_in.sck <= 1'b0;
    end
  endtask

  task automatic send_frame(input dbg_proto_pkg::opcode_t op, input logic [7:0] p0,
                            input logic [7:0] p1, input logic [7:0] p2, input int nparams,
                            input logic with_reply, output logic [7:0] rx_reply);
    logic [23:0] params;
    logic [7:0]  ignored;
    int          i;
    params = {p0, p1, p2};
    spi_in.cs_n <= 1'b0;
    repeat (4) @(posedge clk);
    xfer_byte(8'(op), ignored);
    for (i = 0; i < nparams; i++) begin
      xfer_byte(params[23 - 8 * i -: 8], ignored);
    end
    rx_reply = 8'h00;
    // Dummy byte clocks the answer out
    if (with_reply) begin
      xfer_byte(8'h00, rx_reply);
    end
    repeat (4) @(posedge clk);
    spi_in.cs_n <= 1'b1;
    repeat (6) @(posedge clk);
  endtask

  task automatic command(input dbg_proto_pkg::opcode_t op, input logic [7:0] p0,
                         input logic [7:0] p1, input logic [7:0] p2);
    logic [7:0] ignored;
    send_frame(op, p0, p1, p2, int'(dbg_proto_pkg::param_count(op)), 1'b0, ignored);
  endtask

  task automatic query(input dbg_proto_pkg::opcode_t op, input logic [7:0] p0,
                       input logic [7:0] p1, output logic [7:0] rx_reply);
    send_frame(op, p0, p1, 8'h00, int'(dbg_proto_pkg::param_count(op)), 1'b1, rx_reply);
  endtask

  task automatic start_read(input logic [15:0] a);
    bus_in <= '{addr: a, rd_n: 1'b0};
  endtask

  task automatic end_read();
    bus_in.rd_n <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  initial begin
    seed          = 32'h372d1248;
    rst_n         = 1'b0;
    spi_in        = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    bus_in        = '{addr: 16'h0000, rd_n: 1'b1};
    expect_run    = 1'b0;
    expect_halted = 1'b0;
    exp_hit       = 3'd0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    check_byte("halt after reset", {7'd0, halt}, 8'h00);
    check_byte("miso after reset", {7'd0, miso}, 8'h00);

    // Identity queries
    query(dbg_proto_pkg::get_cookie, 8'h00, 8'h00, reply);
    check_byte("get_cookie", reply, 8'haf);
    query(dbg_proto_pkg::get_version, 8'h00, 8'h00, reply);
    check_byte("get_version", reply, 8'h02);

    // Poke then peek through an alias above the memory size
    for (k = 0; k < 8; k++) begin
      addr = 16'($random(seed));
      data = 8'($random(seed));
      command(dbg_proto_pkg::mem_poke, addr[7:0], addr[15:8], data);
      mem_model[int'(addr) & MEM_MASK] = data;
      addr = addr ^ 16'h8000;
      query(dbg_proto_pkg::mem_peek, addr[7:0], addr[15:8], reply);
      check_byte("mem_peek", reply, mem_model[int'(addr) & MEM_MASK]);
    end
    command(dbg_proto_pkg::mem_poke, addr[7:0], addr[15:8], ~data);
    mem_model[int'(addr) & MEM_MASK] = ~data;
    foreach (mem_model[a]) begin
      query(dbg_proto_pkg::mem_peek, 8'(a), 8'(a >> 8), reply);
      check_byte("mem_peek after overwrite", reply, mem_model[a]);
    end

    // Poke frame cut off before its data byte
    command(dbg_proto_pkg::mem_poke, 8'h23, 8'h01, 8'h5a);
    command(dbg_proto_pkg::mem_poke, 8'h24, 8'h01, 8'ha5);
    send_frame(dbg_proto_pkg::mem_poke, 8'h23, 8'h01, 8'h00, 2, 1'b0, reply);
    query(dbg_proto_pkg::mem_peek, 8'h23, 8'h01, reply);
    check_byte("mem_peek after cut-off poke", reply, 8'h5a);

    // Single breakpoint in slot 3
    bp_addr    = 16'($random(seed));
    other_addr = bp_addr ^ 16'h8000;
    dup_addr   = bp_addr ^ 16'h00ff;
    command(dbg_proto_pkg::set_breakpoint, 8'd3, bp_addr[7:0], bp_addr[15:8]);
    command(dbg_proto_pkg::enable_breakpoints, 8'h00, 8'h00, 8'h00);
    exp_hit    <= 3'd3;
    expect_run <= 1'b1;
    start_read(other_addr);
    repeat (8) @(posedge clk);
    end_read();
    expect_run <= 1'b0;
    start_read(bp_addr);
    wait_halt(1'b1, 4, "halt on a breakpoint read");
    check_byte("hit_index", {5'd0, hit_index}, 8'd3);
    expect_halted <= 1'b1;
    end_read();

    // Resume holds halt until the stored address is read again
    command(dbg_proto_pkg::resume, 8'h00, 8'h00, 8'h00);
    start_read(other_addr);
    repeat (8) @(posedge clk);
    end_read();
    expect_halted <= 1'b0;
    start_read(bp_addr);
    wait_halt(1'b0, 8, "halt release after resume");
    expect_run <= 1'b1;
    repeat (8) @(posedge clk);
    end_read();

    // Lower slot wins when two share one address
    command(dbg_proto_pkg::set_breakpoint, 8'd5, dup_addr[7:0], dup_addr[15:8]);
    command(dbg_proto_pkg::set_breakpoint, 8'd1, dup_addr[7:0], dup_addr[15:8]);
    exp_hit    <= 3'd1;
    expect_run <= 1'b0;
    start_read(dup_addr);
    wait_halt(1'b1, 4, "halt on a shared breakpoint");
    expect_halted <= 1'b1;
    end_read();
    command(dbg_proto_pkg::resume, 8'h00, 8'h00, 8'h00);
    expect_halted <= 1'b0;
    start_read(dup_addr);
    wait_halt(1'b0, 8, "halt release on the shared breakpoint");
    expect_run <= 1'b1;
    repeat (4) @(posedge clk);
    end_read();

    // Disabled table and then cleared slots
    command(dbg_proto_pkg::disable_breakpoints, 8'h00, 8'h00, 8'h00);
    start_read(dup_addr);
    repeat (8) @(posedge clk);
    end_read();
    command(dbg_proto_pkg::enable_breakpoints, 8'h00, 8'h00, 8'h00);
    command(dbg_proto_pkg::clear_breakpoint, 8'd1, 8'h00, 8'h00);
    command(dbg_proto_pkg::clear_breakpoint, 8'd5, 8'h00, 8'h00);
    start_read(dup_addr);
    repeat (8) @(posedge clk);
    end_read();
    expect_run <= 1'b0;

    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule
